// ==== src/rsa_cfg.svh ====
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// array edge, also the number of lanes and banks
`define RSA_DIM   4

// matrix word width, sums and products wrap at this width
`define RSA_DW    16

// row, column, lane or step index
`define RSA_IDX_W 2

// wishbone word address
// top bit selects the control/status register
// below it sit region, lane and index
`define RSA_ADR_W 7

`endif

// ==== src/rsa_pkg.sv ====
`include "rsa_cfg.svh"

package rsa_pkg;

    typedef logic [`RSA_DW-1:0]    data_t;   // one matrix word
    typedef logic [`RSA_IDX_W-1:0] idx_t;    // lane, row, column or step

    // bank regions, lane l holds row l of A, M, C and column l of B
    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_B = 2'd1,
        REG_M = 2'd2,
        REG_C = 2'd3
    } region_e;

    typedef struct packed {
        logic  valid;
        logic  first;   // step 0, restarts the accumulator
        data_t data;
    } operand_t;

    typedef enum logic [2:0] {
        IDLE,
        FEED,
        WAIT,
        DRAIN,
        FINISH
    } ctrl_state_e;

endpackage

// ==== src/pe_mac.sv ====
`timescale 1ns/1ns

module pe_mac (
    input  logic              clk,
    input  logic              i_reset,
    input  rsa_pkg::operand_t i_west,    // A word, moving east
    input  rsa_pkg::operand_t i_south,   // B word, moving north
    input  logic              i_shift,
    input  rsa_pkg::data_t    i_din,     // eastern neighbour's accumulator
    output rsa_pkg::operand_t o_east,
    output rsa_pkg::operand_t o_north,
    output rsa_pkg::data_t    o_dout
);

    import rsa_pkg::*;

    data_t acc;
    data_t product;
    logic  step;

    assign product = i_west.data * i_south.data;   // low half of the product
    assign step    = i_west.valid && i_south.valid;

    // the accumulator doubles as one stage of the westward result chain
    always_ff @(posedge clk) begin
        if (i_shift) begin
            acc <= i_din;
        end else if (step) begin
            if (i_west.first) begin
                acc <= product;            // new run, drop the old sum
            end else begin
                acc <= acc + product;
            end
        end
    end

    // operands hop one element per cycle
    always_ff @(posedge clk) begin
        o_east  <= i_west;
        o_north <= i_south;
        if (i_reset) begin
            o_east.valid  <= 1'b0;
            o_north.valid <= 1'b0;
        end
    end

    assign o_dout = acc;

endmodule

// ==== src/pe_array.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module pe_array (
    input  logic              clk,
    input  logic              i_reset,
    input  rsa_pkg::operand_t i_row_op [`RSA_DIM],   // west edge, one per row
    input  rsa_pkg::operand_t i_col_op [`RSA_DIM],   // south edge, one per column
    input  logic              i_shift,
    output rsa_pkg::data_t    o_row_out [`RSA_DIM]   // column 0 results
);

    import rsa_pkg::*;

    // row 0 is the south row, column 0 the west column
    operand_t a_w   [`RSA_DIM][`RSA_DIM+1];   // a_w[r][c] enters PE(r,c) from the west
    operand_t b_w   [`RSA_DIM+1][`RSA_DIM];   // b_w[r][c] enters PE(r,c) from the south
    data_t    res_w [`RSA_DIM][`RSA_DIM+1];   // res_w[r][c] is PE(r,c)'s accumulator

    for (genvar r = 0; r < `RSA_DIM; r++) begin : g_row_edge
        assign a_w[r][0]          = i_row_op[r];
        assign res_w[r][`RSA_DIM] = '0;           // zeros shift in from the east
        assign o_row_out[r]       = res_w[r][0];
    end

    for (genvar c = 0; c < `RSA_DIM; c++) begin : g_col_edge
        assign b_w[0][c] = i_col_op[c];
    end

    // east column and north row outputs land in the spare slots and go nowhere
    for (genvar r = 0; r < `RSA_DIM; r++) begin : g_row
        for (genvar c = 0; c < `RSA_DIM; c++) begin : g_col
            pe_mac u_pe (
                .clk     (clk),
                .i_reset (i_reset),
                .i_west  (a_w[r][c]),
                .i_south (b_w[r][c]),
                .i_shift (i_shift),
                .i_din   (res_w[r][c+1]),
                .o_east  (a_w[r][c+1]),
                .o_north (b_w[r+1][c]),
                .o_dout  (res_w[r][c])
            );
        end
    end

endmodule

// ==== src/operand_skew.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module operand_skew (
    input  logic              clk,
    input  logic              i_reset,
    input  rsa_pkg::operand_t i_op [`RSA_DIM],
    output rsa_pkg::operand_t o_op [`RSA_DIM]
);

    import rsa_pkg::*;

    // lane 0 enters the array without delay
    assign o_op[0] = i_op[0];

    // lane l runs through l registers, so step k meets its partner on the diagonal
    for (genvar l = 1; l < `RSA_DIM; l++) begin : g_lane
        operand_t stage [l];

        always_ff @(posedge clk) begin
            stage[0] <= i_op[l];
            for (int s = 1; s < l; s++) begin
                stage[s] <= stage[s-1];
            end
            if (i_reset) begin
                for (int s = 0; s < l; s++) begin
                    stage[s].valid <= 1'b0;
                end
            end
        end

        assign o_op[l] = stage[l-1];
    end

endmodule

// ==== src/temp_bank.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module temp_bank (
    input  logic                   clk,
    input  logic                   i_rd_en,
    input  logic [`RSA_IDX_W+1:0]  i_rd_adr,   // {region, index}
    output rsa_pkg::data_t         o_rd_dat,
    input  logic                   i_wr_en,
    input  logic [`RSA_IDX_W+1:0]  i_wr_adr,
    input  rsa_pkg::data_t         i_wr_dat
);

    import rsa_pkg::*;

    localparam int DEPTH = 4 * `RSA_DIM;   // four regions per lane

    data_t mem [DEPTH];

    // port B, host data and C results
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_adr] <= i_wr_dat;
        end
    end

    // port A, registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_dat <= mem[i_rd_adr];
        end
    end

endmodule

// ==== src/rsa_ctrl.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module rsa_ctrl (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [`RSA_ADR_W-1:0]  i_wb_adr,
    input  rsa_pkg::data_t         i_wb_dat,
    output rsa_pkg::data_t         o_wb_dat,
    output logic                   o_wb_ack,
    output logic                   o_rd_en,
    output logic [`RSA_IDX_W+1:0]  o_rd_adr,
    input  rsa_pkg::data_t         i_rd_dat [`RSA_DIM],
    output logic [`RSA_DIM-1:0]    o_wr_en,
    output logic [`RSA_IDX_W+1:0]  o_wr_adr,
    output rsa_pkg::data_t         o_wr_dat [`RSA_DIM],
    output rsa_pkg::operand_t      o_feed_a [`RSA_DIM],
    output rsa_pkg::operand_t      o_feed_b [`RSA_DIM],
    output logic                   o_shift,
    input  rsa_pkg::data_t         i_row_out [`RSA_DIM]
);

    import rsa_pkg::*;

    localparam int CNT_W = `RSA_IDX_W + 1;
    localparam logic [CNT_W-1:0] STEP_LAST  = CNT_W'(2 * `RSA_DIM - 1);   // FEED and WAIT
    localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(`RSA_DIM);

    ctrl_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic             busy, done;
    logic             csr_sel, accept, run_start, host_rd, host_wr;
    region_e          wb_region;
    idx_t             wb_lane, wb_idx;
    logic             pend, csr_q;
    idx_t             lane_q;
    data_t            status;
    logic             a_q, b_q, first_q;   // feed read pipeline
    data_t            a_hold [`RSA_DIM];
    logic             m_q, c_wr_q;         // drain pipeline
    idx_t             m_idx_q, c_idx_q;
    data_t            sum_q [`RSA_DIM];

    assign csr_sel   = i_wb_adr[`RSA_ADR_W-1];
    assign wb_region = region_e'(i_wb_adr[2*`RSA_IDX_W +: 2]);
    assign wb_lane   = i_wb_adr[`RSA_IDX_W +: `RSA_IDX_W];
    assign wb_idx    = i_wb_adr[`RSA_IDX_W-1:0];
    assign busy      = (state != IDLE);
    assign status    = {{(`RSA_DW-2){1'b0}}, done, busy};

    // bank words wait out a run, the status register answers at once
    assign accept    = i_wb_cyc && i_wb_stb && !pend && !o_wb_ack && (csr_sel || !busy);
    assign run_start = accept && csr_sel && i_wb_we && i_wb_dat[0] && !busy;
    assign host_rd   = accept && !csr_sel && !i_wb_we;
    assign host_wr   = accept && !csr_sel && i_wb_we;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pend     <= 1'b0;
            o_wb_ack <= 1'b0;
        end else begin
            pend     <= accept;   // bank read cycle
            o_wb_ack <= pend;     // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            csr_q  <= csr_sel;
            lane_q <= wb_lane;
        end
        if (pend) begin
            o_wb_dat <= csr_q ? status : i_rd_dat[lane_q];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (run_start) begin
                        state <= FEED;
                        done  <= 1'b0;
                    end
                end
                FEED: if (cnt == STEP_LAST) begin   // A and B alternate on the one read port
                    state <= WAIT;
                    cnt   <= '0;
                end
                WAIT: if (cnt == STEP_LAST) begin   // last step crosses to the far corner
                    state <= DRAIN;
                    cnt   <= '0;
                end
                DRAIN: if (cnt == DRAIN_LAST) begin
                    state <= FINISH;
                    cnt   <= '0;
                end
                FINISH: begin                       // last C word is written here
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            a_q    <= 1'b0;
            b_q    <= 1'b0;
            m_q    <= 1'b0;
            c_wr_q <= 1'b0;
        end else begin
            a_q    <= (state == FEED) && !cnt[0];
            b_q    <= (state == FEED) && cnt[0];
            m_q    <= (state == DRAIN) && (cnt != DRAIN_LAST);
            c_wr_q <= m_q;
        end
    end

    always_ff @(posedge clk) begin
        first_q <= (cnt[CNT_W-1:1] == '0);
        m_idx_q <= cnt[`RSA_IDX_W-1:0];
        c_idx_q <= m_idx_q;
        for (int l = 0; l < `RSA_DIM; l++) begin
            if (a_q) begin
                a_hold[l] <= i_rd_dat[l];                // waits for its B partner
            end
            if (m_q) begin
                sum_q[l] <= i_row_out[l] + i_rd_dat[l];  // M adder
            end
        end
    end

    always_comb begin
        o_rd_en  = host_rd;
        o_rd_adr = {wb_region, wb_idx};
        if (state == FEED) begin
            o_rd_en  = 1'b1;
            o_rd_adr = {cnt[0] ? REG_B : REG_A, cnt[CNT_W-1:1]};
        end else if (state == DRAIN && cnt != DRAIN_LAST) begin
            o_rd_en  = 1'b1;
            o_rd_adr = {REG_M, cnt[`RSA_IDX_W-1:0]};
        end
    end

    always_comb begin
        o_wr_en  = '0;
        o_wr_adr = {wb_region, wb_idx};
        for (int l = 0; l < `RSA_DIM; l++) begin
            o_wr_dat[l] = c_wr_q ? sum_q[l] : i_wb_dat;
        end
        if (c_wr_q) begin
            o_wr_en  = '1;              // row l of C on every lane
            o_wr_adr = {REG_C, c_idx_q};
        end else if (host_wr) begin
            o_wr_en[wb_lane] = 1'b1;
        end
    end

    always_comb begin
        for (int l = 0; l < `RSA_DIM; l++) begin
            o_feed_a[l] = '{valid: b_q, first: first_q, data: a_hold[l]};
            o_feed_b[l] = '{valid: b_q, first: first_q, data: i_rd_dat[l]};
        end
    end

    // one cycle of M read latency before the first shift
    assign o_shift = (state == DRAIN) && (cnt != '0);

endmodule

// ==== src/rsa_top.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module rsa_top (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [`RSA_ADR_W-1:0]  i_wb_adr,
    input  rsa_pkg::data_t         i_wb_dat,
    output rsa_pkg::data_t         o_wb_dat,
    output logic                   o_wb_ack
);

    import rsa_pkg::*;

    logic                  rd_en;
    logic [`RSA_IDX_W+1:0] rd_adr;
    data_t                 rd_dat [`RSA_DIM];
    logic [`RSA_DIM-1:0]   wr_en;
    logic [`RSA_IDX_W+1:0] wr_adr;
    data_t                 wr_dat [`RSA_DIM];
    operand_t              feed_a [`RSA_DIM];   // bank side, unskewed
    operand_t              feed_b [`RSA_DIM];
    operand_t              row_op [`RSA_DIM];   // array side, staggered
    operand_t              col_op [`RSA_DIM];
    logic                  shift;
    data_t                 row_out [`RSA_DIM];

    rsa_ctrl u_ctrl (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_rd_en   (rd_en),
        .o_rd_adr  (rd_adr),
        .i_rd_dat  (rd_dat),
        .o_wr_en   (wr_en),
        .o_wr_adr  (wr_adr),
        .o_wr_dat  (wr_dat),
        .o_feed_a  (feed_a),
        .o_feed_b  (feed_b),
        .o_shift   (shift),
        .i_row_out (row_out)
    );

    for (genvar l = 0; l < `RSA_DIM; l++) begin : g_bank
        temp_bank u_bank (
            .clk      (clk),
            .i_rd_en  (rd_en),
            .i_rd_adr (rd_adr),
            .o_rd_dat (rd_dat[l]),
            .i_wr_en  (wr_en[l]),
            .i_wr_adr (wr_adr),
            .i_wr_dat (wr_dat[l])
        );
    end

    operand_skew u_skew_a (     // rows, west edge
        .clk     (clk),
        .i_reset (i_reset),
        .i_op    (feed_a),
        .o_op    (row_op)
    );

    operand_skew u_skew_b (     // columns, south edge
        .clk     (clk),
        .i_reset (i_reset),
        .i_op    (feed_b),
        .o_op    (col_op)
    );

    pe_array u_array (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_row_op  (row_op),
        .i_col_op  (col_op),
        .i_shift   (shift),
        .o_row_out (row_out)
    );

endmodule

// ==== verif/rsa_tb.sv ====
`timescale 1ns/1ns
`include "rsa_cfg.svh"

module rsa_tb;

    import rsa_pkg::*;

    localparam int N     = `RSA_DIM;
    localparam int WORDS = 4 * N * N;   // all regions of all lanes
    // about 410 bus accesses of 3 cycles each plus four runs of about 22 cycles
    // come to roughly 1300 cycles
    localparam int MAX_CYCLES = 4000;

    typedef logic [`RSA_ADR_W-1:0] adr_t;

    localparam adr_t CSR_ADR = adr_t'(1 << (`RSA_ADR_W - 1));

    logic        clk;
    logic        reset;
    logic        wb_cyc, wb_stb, wb_we;
    adr_t        wb_adr;
    data_t       wb_dat_w;
    data_t       wb_dat_r;
    logic        wb_ack;
    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsr;

    data_t a_m   [N][N];
    data_t b_m   [N][N];
    data_t m_m   [N][N];
    data_t c_exp [N][N];
    data_t shadow [WORDS];   // last value written to each bank word

    rsa_top rsa_top_inst (
        .clk      (clk),
        .i_reset  (reset),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles with %0d checks and %0d errors",
                     cycles, checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr[0];
        lfsr    = lfsr >> 1;
        if (out_bit) begin
            lfsr = lfsr ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return out_bit;
    endfunction

    function automatic data_t rand_word();
        data_t w;
        w = '0;
        for (int i = 0; i < `RSA_DW; i++) begin
            w = {w[`RSA_DW-2:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic adr_t bank_adr(input region_e rgn, input int lane, input int idx);
        return {1'b0, rgn, idx_t'(lane), idx_t'(idx)};
    endfunction

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR time=%0t %s", $time, what);
            errors++;
        end
    endtask

    // one wishbone access that starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input adr_t adr, input data_t wdat,
                             output data_t rdat, output int lat);
        lat      = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!wb_ack);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        check_cond(!wb_ack, "o_wb_ack stayed high for more than one cycle");
    endtask

    task automatic randomize_operands();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_m[i][j] = rand_word();
                b_m[i][j] = rand_word();
                m_m[i][j] = rand_word();
            end
        end
    endtask

    // C = A*B + M with every sum and product cut to the word width
    task automatic compute_model();
        data_t acc;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                acc = m_m[i][j];
                for (int k = 0; k < N; k++) begin
                    acc = acc + a_m[i][k] * b_m[k][j];
                end
                c_exp[i][j] = acc;
            end
        end
    endtask

    task automatic load_operands();
        data_t unused;
        int    lat;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                bus_cycle(1'b1, bank_adr(REG_A, i, j), a_m[i][j], unused, lat);
                bus_cycle(1'b1, bank_adr(REG_B, j, i), b_m[i][j], unused, lat);   // column j
                bus_cycle(1'b1, bank_adr(REG_M, i, j), m_m[i][j], unused, lat);
            end
        end
    endtask

    task automatic start_run();
        data_t unused;
        int    lat;
        bus_cycle(1'b1, CSR_ADR, data_t'(1), unused, lat);
    endtask

    task automatic wait_done();
        data_t st;
        int    lat;
        do begin
            bus_cycle(1'b0, CSR_ADR, '0, st, lat);
        end while (!st[1]);
        check_value("o_wb_dat status", data_t'(2), st);   // done set and busy clear
    endtask

    task automatic compare_c();
        data_t got;
        int    lat;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                bus_cycle(1'b0, bank_adr(REG_C, i, j), '0, got, lat);
                check_value($sformatf("o_wb_dat C[%0d][%0d]", i, j), c_exp[i][j], got);
            end
        end
    endtask

    initial begin
        data_t got;
        data_t st;
        int    lat;
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        lfsr     = 32'hb070_2e8e;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet bus and clear status after reset
        repeat (4) begin
            @(posedge clk);
            #1;
            check_cond(!wb_ack, "o_wb_ack rose with no request");
        end
        bus_cycle(1'b0, CSR_ADR, '0, st, lat);
        check_value("o_wb_dat status", '0, st);
        check_cond(lat == 2, $sformatf("status read acked after %0d cycles, not 2", lat));

        // every bank word written and then read back
        for (int w = 0; w < WORDS; w++) begin
            shadow[w] = rand_word();
            bus_cycle(1'b1, adr_t'(w), shadow[w], got, lat);
            check_cond(lat == 2, $sformatf("write of word %0d acked after %0d cycles", w, lat));
        end
        for (int w = 0; w < WORDS; w++) begin
            bus_cycle(1'b0, adr_t'(w), '0, got, lat);
            check_value($sformatf("o_wb_dat word %0d", w), shadow[w], got);
            check_cond(lat == 2, $sformatf("read of word %0d acked after %0d cycles", w, lat));
        end

        // identity A and zero M pass B straight through
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_m[i][j]   = (i == j) ? data_t'(1) : data_t'(0);
                b_m[i][j]   = rand_word();
                m_m[i][j]   = '0;
                c_exp[i][j] = b_m[i][j];
            end
        end
        load_operands();
        start_run();
        wait_done();
        compare_c();

        // random operands against the model
        randomize_operands();
        compute_model();
        load_operands();
        start_run();
        wait_done();
        compare_c();

        // bank read held off while the run is busy
        randomize_operands();
        compute_model();
        load_operands();
        start_run();
        bus_cycle(1'b0, CSR_ADR, '0, st, lat);
        check_value("o_wb_dat status", data_t'(1), st);   // busy with done cleared
        check_cond(lat == 2, $sformatf("busy status read acked after %0d cycles, not 2", lat));
        bus_cycle(1'b0, bank_adr(REG_C, N-1, N-1), '0, got, lat);
        check_cond(lat > 2, "C read was acked while the run was still busy");
        check_value("o_wb_dat held C read", c_exp[N-1][N-1], got);
        bus_cycle(1'b0, CSR_ADR, '0, st, lat);
        check_value("o_wb_dat status", data_t'(2), st);
        compare_c();

        // fresh data again so the accumulators must restart
        randomize_operands();
        compute_model();
        load_operands();
        start_run();
        wait_done();
        compare_c();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/rsa_pkg.sv
src/pe_mac.sv
src/pe_array.sv
src/operand_skew.sv
src/temp_bank.sv
src/rsa_ctrl.sv
src/rsa_top.sv
verif/rsa_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module rsa_tb -o rsa_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/rsa_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation ended with an error status, see sim.log"
    exit 1
fi

# the testbench prints the fail message on any failed check or timeout
if grep -q "tests failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi

echo "PASS"
exit 0
